/* all.f */
+incdir+testbench
rtl/cpuPkg.sv
rtl/registerFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/hazardUnit.sv
rtl/cpu.sv
testbench/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpuTb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing

BIN  := $(BUILD_DIR)/$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) testbench/cpuModel.svh

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^No errors$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/cpuModel.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Instruction-set model that runs prog and fills the expected trace queues
function automatic void runModel();
    wordT       regs [16];
    wordT       mem [256];
    logic       zf, vf, nf, taken, write;
    int         progPc, sum, off;
    wordT       ins, a, b, r, addr;
    logic [3:0] rd, sh;
    for (int i = 0; i < 16; i++) regs[i] = '0;
    for (int i = 0; i < 256; i++) mem[i] = '0; // Data memory starts cleared
    {zf, vf, nf} = 3'b000;
    taken = 1'b0;
    progPc = 0;
    expHaltPc = 0;
    expRegQ.delete();
    expStoreQ.delete();
    while (progPc >= 0 && progPc < prog.size()) begin
        ins    = prog[progPc];
        rd     = ins[11:8];
        a      = regs[ins[7:4]];
        b      = regs[ins[3:0]];
        sh     = ins[3:0];
        addr   = a + {{12{ins[3]}}, ins[3:0]}; // Base plus signed word offset
        progPc = progPc + 1;
        write  = 1'b0;
        r      = '0;
        if (ins[15:12] == 4'hF) begin
            expHaltPc = progPc; // Fetch stops one past HLT
            break;
        end
        case (ins[15:12])
            4'h0, 4'h1: begin
                r = (ins[15:12] == 4'h0) ? a + b : a - b;
                if (ins[15:12] == 4'h0)
                    sum = int'($signed(a)) + int'($signed(b));
                else
                    sum = int'($signed(a)) - int'($signed(b));
                vf    = (sum > 32767) || (sum < -32768); // Out of 16-bit signed range
                nf    = r[15];
                zf    = (r == 0);
                write = 1'b1;
            end
            4'h2: begin
                r     = a ^ b;
                zf    = (r == 0);
                write = 1'b1;
            end
            4'h3: begin
                r     = a & b;
                zf    = (r == 0);
                write = 1'b1;
            end
            4'h4: begin
                r     = a << sh;
                zf    = (r == 0);
                write = 1'b1;
            end
            4'h5: begin
                r     = $signed(a) >>> sh;
                zf    = (r == 0);
                write = 1'b1;
            end
            4'h6: begin
                r     = (a >> sh) | (a << (16 - sh));
                zf    = (r == 0);
                write = 1'b1;
            end
            4'h8: begin
                r     = mem[addr[7:0]];
                write = 1'b1;
            end
            4'h9: begin
                mem[addr[7:0]] = regs[rd];
                expStoreQ.push_back({addr, regs[rd]});
            end
            4'hA: begin
                r     = {{8{ins[7]}}, ins[7:0]};
                write = 1'b1;
            end
            4'hB: begin
                r     = {ins[7:0], regs[rd][7:0]}; // Keep low byte
                write = 1'b1;
            end
            4'hC: begin
                case (ins[11:9])
                    3'd0: taken = !zf;
                    3'd1: taken = zf;
                    3'd2: taken = !zf && !nf;
                    3'd3: taken = nf;
                    3'd4: taken = zf || !nf;
                    3'd5: taken = zf || nf;
                    3'd6: taken = vf;
                    default: taken = 1'b1;
                endcase
                off = int'($signed(ins[8:0]));
                if (taken) progPc = progPc + off; // progPc already points past the branch
            end
            default: ; // 7, D and E
        endcase
        if (write && rd != 0) begin
            regs[rd] = r;
            expRegQ.push_back({12'h000, rd, r});
        end
    end
endfunction

`endif

/* testbench/cpuTb.sv */
module cpuTb;
    import cpuPkg::*;

    logic        clk;
    logic        reset;
    logic        progWrite;
    logic [7:0]  progAddr;
    wordT        progData;
    wordT        pc;
    logic        hlt;
    logic        retireValid;
    regAddrT     retireReg;
    wordT        retireData;
    logic        storeValid;
    wordT        storeAddr;
    wordT        storeData;

    wordT        prog [$];      // Program being run
    logic [31:0] expRegQ [$];   // {reg, data}
    logic [31:0] expStoreQ [$]; // {addr, data}
    logic [31:0] expEvent;
    int          expHaltPc;     // Fetch PC once halted
    logic [31:0] lcgState = 32'h674c_f4a0;
    string       testName = "none";
    logic        running = 1'b0;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    `include "cpuModel.svh"

    cpu #(.imemAddrWidth(8), .dmemAddrWidth(8)) cpu_inst (
        .clk(clk), .reset(reset),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .pc(pc), .hlt(hlt),
        .retireValid(retireValid), .retireReg(retireReg), .retireData(retireData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {8'h00, lcgState[31:8]}; // Upper bits of the state only
    endfunction

    function automatic wordT regInstr(logic [3:0] op, int rd, int rs, int rt);
        return {op, 4'(rd), 4'(rs), 4'(rt)};
    endfunction

    function automatic wordT byteInstr(logic [3:0] op, int rd, logic [7:0] value);
        return {op, 4'(rd), value};
    endfunction

    function automatic wordT branchInstr(int cond, int off);
        return {4'hC, 3'(cond), 9'(off)};
    endfunction

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Trace compare on the falling edge where the pulses are stable
    always @(negedge clk) begin
        if (retireValid) begin
            if (expRegQ.size() == 0)
                reportFailure($sformatf("%s: unexpected write of r%0d", testName, retireReg));
            expEvent = expRegQ.pop_front();
            checkValue(testName, expEvent, {12'h000, retireReg, retireData});
        end
        if (storeValid) begin
            if (expStoreQ.size() == 0)
                reportFailure($sformatf("%s: unexpected store to %h", testName, storeAddr));
            expEvent = expStoreQ.pop_front();
            checkValue(testName, expEvent, {storeAddr, storeData});
        end
    end

    // Watchdog on each run to halt
    initial begin
        forever begin
            @(posedge clk);
            if (running) begin
                cycleCount++;
                if (cycleCount > cycleLimit)
                    reportFailure($sformatf("%s: timed out waiting for halt", testName));
            end
        end
    end

    // Load prog under reset, run to halt, then check the quiet tail
    task automatic runProgram(input string name);
        testName = name;
        runModel();
        @(posedge clk);
        #1 reset = 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            progWrite = 1'b1;
            progAddr  = 8'(i);
            progData  = prog[i];
            @(posedge clk);
            #1;
        end
        progWrite = 1'b0;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        cycleCount = 0;
        cycleLimit = 40 * prog.size();
        running    = 1'b1;
        @(negedge clk);
        checkValue({name, " reset pc"}, 32'd0, {16'h0000, pc});
        checkValue({name, " reset hlt"}, 32'd0, {31'd0, hlt});
        while (!hlt) @(negedge clk);
        repeat (10) begin
            @(negedge clk);
            checkValue({name, " hlt"}, 32'd1, {31'd0, hlt});
            checkValue({name, " halt pc"}, 32'(expHaltPc), {16'h0000, pc}); // Fetch frozen
        end
        @(posedge clk); // Away from the monitor edge
        running = 1'b0;
        checkValue({name, " reg queue"}, 32'd0, expRegQ.size());
        checkValue({name, " store queue"}, 32'd0, expStoreQ.size());
    endtask

    task automatic buildRandom();
        int   len;
        wordT w;
        prog.delete();
        len = 10 + int'(nextRand() % 51);
        for (int i = 0; i < len - 1; i++) begin
            w = 16'(nextRand());
            if (w[15:12] == 4'hF) w[15:12] = 4'hA; // HLT only at the end
            if (w[15:12] == 4'hC) w[8:0] = 9'(nextRand() % (len - 1 - i)); // Forward only
            prog.push_back(w);
        end
        prog.push_back(16'hF000);
    endtask

    initial begin
        reset = 1'b1;
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;

        // Arithmetic and flags
        prog = {byteInstr(4'hA, 1, 8'h34), byteInstr(4'hB, 1, 8'h7F),
                byteInstr(4'hA, 2, 8'h00), byteInstr(4'hB, 2, 8'h70),
                regInstr(4'h0, 3, 1, 2), branchInstr(6, 1), byteInstr(4'hA, 5, 8'h55),
                regInstr(4'h1, 4, 1, 2), regInstr(4'h2, 6, 3, 1), regInstr(4'h3, 7, 3, 1),
                regInstr(4'h0, 8, 1, 1), regInstr(4'h1, 9, 2, 2), 16'hF000};
        runProgram("arith");

        // Forwarding chains
        prog = {byteInstr(4'hA, 1, 8'h07), regInstr(4'h0, 2, 1, 1), regInstr(4'h0, 3, 2, 1),
                regInstr(4'h1, 4, 3, 2), regInstr(4'h2, 5, 4, 3), regInstr(4'h4, 6, 5, 3),
                regInstr(4'h5, 7, 6, 2), regInstr(4'h6, 8, 7, 5), regInstr(4'h3, 9, 8, 6),
                16'h7000, regInstr(4'h0, 10, 9, 8), byteInstr(4'hB, 10, 8'h12),
                regInstr(4'h0, 11, 10, 10), 16'hF000};
        runProgram("forward");

        // Store and load
        prog = {byteInstr(4'hA, 1, 8'h03), byteInstr(4'hA, 2, 8'h5A),
                regInstr(4'h9, 2, 1, 2),
                regInstr(4'h8, 3, 1, 2), regInstr(4'h0, 4, 3, 3), regInstr(4'h8, 5, 1, 2),
                regInstr(4'h9, 5, 0, 7), regInstr(4'h8, 6, 0, 7), regInstr(4'h1, 7, 6, 2),
                regInstr(4'h9, 4, 1, 15), regInstr(4'h8, 8, 1, 15), regInstr(4'h9, 8, 8, 1),
                16'hF000};
        runProgram("memory");

        // Every condition against zero, negative, positive and overflow flags
        prog = {byteInstr(4'hA, 1, 8'h05), byteInstr(4'hA, 2, 8'h7F),
                byteInstr(4'hB, 2, 8'h7F)};
        for (int c = 0; c < 8; c++) begin
            for (int s = 0; s < 4; s++) begin
                case (s)
                    0: prog.push_back(regInstr(4'h1, 3, 1, 1));
                    1: prog.push_back(regInstr(4'h1, 3, 0, 1));
                    2: prog.push_back(regInstr(4'h1, 3, 1, 0));
                    default: prog.push_back(regInstr(4'h0, 3, 2, 2));
                endcase
                if (s == 2) prog.push_back(16'hD000); // Branch one slot later
                prog.push_back(branchInstr(c, 1));
                prog.push_back(byteInstr(4'hA, 9, 8'(c * 16 + s)));
            end
        end
        prog.push_back(16'hF000);
        runProgram("branch");

        // Nothing behind HLT may run
        prog = {byteInstr(4'hA, 1, 8'h01), regInstr(4'h0, 2, 1, 1), 16'hF000,
                byteInstr(4'hA, 3, 8'h03), regInstr(4'h9, 1, 0, 0)};
        runProgram("halt");

        for (int n = 0; n < 20; n++) begin
            buildRandom();
            runProgram($sformatf("random%0d", n));
        end

        $display("No errors");
        $finish;
    end

endmodule

/* rtl/cpu.sv */
module cpu #(
    parameter int imemAddrWidth = 8,
    parameter int dmemAddrWidth = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     progWrite,   // Program load, used during reset
    input  logic [imemAddrWidth-1:0] progAddr,
    input  cpuPkg::wordT             progData,
    output cpuPkg::wordT             pc,
    output logic                     hlt,
    output logic                     retireValid, // One pulse per register write
    output cpuPkg::regAddrT          retireReg,
    output cpuPkg::wordT             retireData,
    output logic                     storeValid,  // One pulse per store
    output cpuPkg::wordT             storeAddr,
    output cpuPkg::wordT             storeData
);
    import cpuPkg::*;

    // IF/ID
    wordT    instrId, pcId;
    // Decode to fetch and hazard unit
    logic    branchTaken, haltSeen, branchId, storeId;
    wordT    branchTarget;
    regAddrT srcAId, srcBId;
    // ID/EX
    opcodeT  opcodeEx;
    wordT    regAEx, regBEx, immEx;
    regAddrT rdEx, rsEx, rtEx;
    logic    memReadEx, memWriteEx, regWriteEx, setsFlagsEx;
    // EX/MEM
    flagsT   flags;
    wordT    resultMem, storeDataMem;
    regAddrT rdMem;
    logic    regWriteMem, memReadMem, memWriteMem, haltMem;
    // Hazard controls
    forwardT forwardA, forwardB;
    logic    forwardStore, stall;

    fetchStage #(.imemAddrWidth(imemAddrWidth)) fetchInst (
        .clk(clk), .reset(reset),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .stall(stall), .branchTaken(branchTaken), .branchTarget(branchTarget),
        .haltSeen(haltSeen),
        .pc(pc), .instrId(instrId), .pcId(pcId)
    );

    decodeStage decodeInst (
        .clk(clk), .reset(reset), .stall(stall),
        .instrId(instrId), .pcId(pcId), .flags(flags),
        .wbWrite(retireValid), .wbReg(retireReg), .wbData(retireData), // Writeback port
        .branchTaken(branchTaken), .branchTarget(branchTarget), .haltSeen(haltSeen),
        .srcAId(srcAId), .srcBId(srcBId), .branchId(branchId), .storeId(storeId),
        .opcode(opcodeEx), .regA(regAEx), .regB(regBEx), .imm(immEx),
        .rdEx(rdEx), .rsEx(rsEx), .rtEx(rtEx),
        .memRead(memReadEx), .memWrite(memWriteEx), .regWrite(regWriteEx),
        .setsFlags(setsFlagsEx)
    );

    executeStage executeInst (
        .clk(clk), .reset(reset),
        .opcode(opcodeEx), .regA(regAEx), .regB(regBEx), .imm(immEx), .rdEx(rdEx),
        .memRead(memReadEx), .memWrite(memWriteEx), .regWrite(regWriteEx),
        .setsFlags(setsFlagsEx),
        .forwardA(forwardA), .forwardB(forwardB), .wbData(retireData),
        .flags(flags), .result(resultMem), .storeDataMem(storeDataMem), .rdMem(rdMem),
        .regWriteMem(regWriteMem), .memReadMem(memReadMem), .memWriteMem(memWriteMem),
        .haltMem(haltMem)
    );

    memoryStage #(.dmemAddrWidth(dmemAddrWidth)) memoryInst (
        .clk(clk), .reset(reset),
        .result(resultMem), .storeDataMem(storeDataMem), .rdMem(rdMem),
        .regWriteMem(regWriteMem), .memReadMem(memReadMem), .memWriteMem(memWriteMem),
        .haltMem(haltMem), .forwardStore(forwardStore),
        .wbWrite(retireValid), .wbReg(retireReg), .wbData(retireData), .hlt(hlt),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

    hazardUnit hazardInst (
        .rsEx(rsEx), .rtEx(rtEx), .rdEx(rdEx),
        .memReadEx(memReadEx), .setsFlagsEx(setsFlagsEx),
        .rdMem(rdMem), .regWriteMem(regWriteMem), .memReadMem(memReadMem),
        .memWriteMem(memWriteMem),
        .wbReg(retireReg), .wbWrite(retireValid),
        .srcAId(srcAId), .srcBId(srcBId), .branchId(branchId), .storeId(storeId),
        .forwardA(forwardA), .forwardB(forwardB), .forwardStore(forwardStore),
        .stall(stall)
    );

endmodule

/* rtl/hazardUnit.sv */
module hazardUnit (
    input  cpuPkg::regAddrT rsEx,
    input  cpuPkg::regAddrT rtEx,
    input  cpuPkg::regAddrT rdEx,
    input  logic            memReadEx,
    input  logic            setsFlagsEx,
    input  cpuPkg::regAddrT rdMem,
    input  logic            regWriteMem,
    input  logic            memReadMem,
    input  logic            memWriteMem,
    input  cpuPkg::regAddrT wbReg,
    input  logic            wbWrite,
    input  cpuPkg::regAddrT srcAId,
    input  cpuPkg::regAddrT srcBId,
    input  logic            branchId,
    input  logic            storeId,
    output cpuPkg::forwardT forwardA,
    output cpuPkg::forwardT forwardB,
    output logic            forwardStore,
    output logic            stall
);
    import cpuPkg::*;

    logic memFwdOk, loadUse, flagStall;

    function automatic forwardT selectForward(regAddrT src, regAddrT memReg, logic memOk,
                                              regAddrT wbRegIn, logic wbOk);
        if (src == '0) return fwdNone;
        if (memOk && memReg == src) return fwdFromMem; // Newer value wins
        if (wbOk && wbRegIn == src) return fwdFromWb;
        return fwdNone;
    endfunction

    assign memFwdOk = regWriteMem && !memReadMem; // Load data not ready in EX/MEM
    assign forwardA = selectForward(rsEx, rdMem, memFwdOk, wbReg, wbWrite);
    assign forwardB = selectForward(rtEx, rdMem, memFwdOk, wbReg, wbWrite);

    // SW right behind LW picks the loaded word in memory
    assign forwardStore = memWriteMem && wbWrite && (wbReg == rdMem) && (rdMem != '0);

    // Store data from a load skips the stall
    assign loadUse = memReadEx && (rdEx != '0) &&
                     ((srcAId == rdEx) || (srcBId == rdEx && !storeId));
    assign flagStall = branchId && setsFlagsEx; // Flags land at end of EX

    assign stall = loadUse || flagStall;

endmodule

/* rtl/memoryStage.sv */
module memoryStage #(
    parameter int dmemAddrWidth = 8
) (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::wordT    result,
    input  cpuPkg::wordT    storeDataMem,
    input  cpuPkg::regAddrT rdMem,
    input  logic            regWriteMem,
    input  logic            memReadMem,
    input  logic            memWriteMem,
    input  logic            haltMem,
    input  logic            forwardStore, // Take store data from MEM/WB
    output logic            wbWrite,
    output cpuPkg::regAddrT wbReg,
    output cpuPkg::wordT    wbData,
    output logic            hlt,
    output logic            storeValid,
    output cpuPkg::wordT    storeAddr,
    output cpuPkg::wordT    storeData
);
    import cpuPkg::*;

    wordT dmem [2**dmemAddrWidth];
    wordT loadData;

    assign storeValid = memWriteMem;
    assign storeAddr  = result;
    assign storeData  = forwardStore ? wbData : storeDataMem; // LW then SW of its value
    assign loadData   = dmem[result[dmemAddrWidth-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**dmemAddrWidth; i++) begin
                dmem[i] <= '0; // Loads of unwritten words read zero
            end
        end else if (memWriteMem) begin
            dmem[result[dmemAddrWidth-1:0]] <= storeData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbWrite <= 1'b0;
            hlt     <= 1'b0;
        end else begin
            wbWrite <= regWriteMem;
            hlt     <= hlt | haltMem; // High from HLT writeback on
        end
    end

    always_ff @(posedge clk) begin
        wbReg  <= rdMem;
        wbData <= memReadMem ? loadData : result;
    end

endmodule

/* rtl/executeStage.sv */
module executeStage (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::opcodeT  opcode,
    input  cpuPkg::wordT    regA,
    input  cpuPkg::wordT    regB,
    input  cpuPkg::wordT    imm,
    input  cpuPkg::regAddrT rdEx,
    input  logic            memRead,
    input  logic            memWrite,
    input  logic            regWrite,
    input  logic            setsFlags,
    input  cpuPkg::forwardT forwardA,
    input  cpuPkg::forwardT forwardB,
    input  cpuPkg::wordT    wbData,      // MEM/WB value
    output cpuPkg::flagsT   flags,
    output cpuPkg::wordT    result,      // EX/MEM result, also forwarded
    output cpuPkg::wordT    storeDataMem,
    output cpuPkg::regAddrT rdMem,
    output logic            regWriteMem,
    output logic            memReadMem,
    output logic            memWriteMem,
    output logic            haltMem
);
    import cpuPkg::*;

    wordT        opA, opB, aluOut;
    logic [31:0] rotWide;
    logic        overflow;

    function automatic wordT pickOperand(forwardT sel, wordT regVal, wordT memVal, wordT wbVal);
        case (sel)
            fwdFromMem: return memVal;
            fwdFromWb:  return wbVal;
            default:    return regVal;
        endcase
    endfunction

    assign opA     = pickOperand(forwardA, regA, result, wbData);
    assign opB     = pickOperand(forwardB, regB, result, wbData); // SW data too
    assign rotWide = {opA, opA} >> imm[3:0];

    always_comb begin
        aluOut   = '0;
        overflow = 1'b0;
        case (opcode)
            opAdd: begin
                aluOut   = opA + opB; // Wraps
                overflow = (opA[15] == opB[15]) && (aluOut[15] != opA[15]);
            end
            opSub: begin
                aluOut   = opA - opB;
                overflow = (opA[15] != opB[15]) && (aluOut[15] != opA[15]);
            end
            opXor:      aluOut = opA ^ opB;
            opAnd:      aluOut = opA & opB;
            opSll:      aluOut = opA << imm[3:0];
            opSra:      aluOut = wordT'($signed(opA) >>> imm[3:0]);
            opRor:      aluOut = rotWide[15:0];
            opLw, opSw: aluOut = opA + imm; // Word address
            opLlb:      aluOut = imm;
            opLhb:      aluOut = {imm[7:0], opA[7:0]};
            default:    aluOut = '0;
        endcase
    end

    // Z for all flag setters, V and N only for ADD and SUB
    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (setsFlags) begin
            flags.zero <= (aluOut == '0);
            if (opcode == opAdd || opcode == opSub) begin
                flags.overflow <= overflow;
                flags.negative <= aluOut[15];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteMem <= 1'b0;
            memReadMem  <= 1'b0;
            memWriteMem <= 1'b0;
            haltMem     <= 1'b0;
        end else begin
            regWriteMem <= regWrite;
            memReadMem  <= memRead;
            memWriteMem <= memWrite;
            haltMem     <= (opcode == opHlt);
        end
    end

    always_ff @(posedge clk) begin
        result       <= aluOut;
        storeDataMem <= opB;
        rdMem        <= rdEx; // Data register for SW
    end

endmodule

/* rtl/decodeStage.sv */
module decodeStage (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,
    input  cpuPkg::wordT     instrId,
    input  cpuPkg::wordT     pcId,
    input  cpuPkg::flagsT    flags,       // Flag register in execute
    input  logic             wbWrite,
    input  cpuPkg::regAddrT  wbReg,
    input  cpuPkg::wordT     wbData,
    output logic             branchTaken,
    output cpuPkg::wordT     branchTarget,
    output logic             haltSeen,
    output cpuPkg::regAddrT  srcAId,      // Sources read in decode, r0 if unused
    output cpuPkg::regAddrT  srcBId,
    output logic             branchId,
    output logic             storeId,
    output cpuPkg::opcodeT   opcode,
    output cpuPkg::wordT     regA,
    output cpuPkg::wordT     regB,
    output cpuPkg::wordT     imm,
    output cpuPkg::regAddrT  rdEx,
    output cpuPkg::regAddrT  rsEx,
    output cpuPkg::regAddrT  rtEx,
    output logic             memRead,
    output logic             memWrite,
    output logic             regWrite,
    output logic             setsFlags
);
    import cpuPkg::*;

    opcodeT  op;
    condT    cond;
    regAddrT rd, rs, rt;
    wordT    readDataA, readDataB, immD;
    logic    regWriteD, setsFlagsD, condMet;

    assign op   = opcodeT'(instrId[15:12]);
    assign cond = condT'(instrId[11:9]);
    assign rd   = instrId[11:8];
    assign rs   = instrId[7:4];
    assign rt   = instrId[3:0];

    assign branchId = (op == opB);
    assign storeId  = (op == opSw);
    assign haltSeen = (op == opHlt);

    registerFile regFileInst (
        .clk(clk), .reset(reset),
        .readRegA(srcAId), .readRegB(srcBId),
        .writeEnable(wbWrite), .writeReg(wbReg), .writeData(wbData),
        .readDataA(readDataA), .readDataB(readDataB)
    );

    always_comb begin
        srcAId     = '0;
        srcBId     = '0;
        immD       = '0;
        regWriteD  = 1'b0;
        setsFlagsD = 1'b0;
        case (op)
            opAdd, opSub, opXor, opAnd: begin
                srcAId     = rs;
                srcBId     = rt;
                regWriteD  = 1'b1;
                setsFlagsD = 1'b1;
            end
            opSll, opSra, opRor: begin
                srcAId     = rs;
                immD       = {12'h000, rt}; // Shift amount
                regWriteD  = 1'b1;
                setsFlagsD = 1'b1;
            end
            opLw: begin
                srcAId    = rs;
                immD      = {{12{rt[3]}}, rt}; // Signed word offset
                regWriteD = 1'b1;
            end
            opSw: begin
                srcAId = rs;
                srcBId = rd; // Store data register
                immD   = {{12{rt[3]}}, rt};
            end
            opLlb, opLhb: begin
                srcAId    = rd; // LHB keeps rd low byte
                immD      = {{8{instrId[7]}}, instrId[7:0]};
                regWriteD = 1'b1;
            end
            default: ;
        endcase
    end

    // Condition against the committed flags
    always_comb begin
        condMet = 1'b0;
        case (cond)
            condNe:     condMet = !flags.zero;
            condEq:     condMet = flags.zero;
            condGt:     condMet = !flags.zero && !flags.negative;
            condLt:     condMet = flags.negative;
            condGe:     condMet = flags.zero || !flags.negative;
            condLe:     condMet = flags.zero || flags.negative;
            condOv:     condMet = flags.overflow;
            condAlways: condMet = 1'b1;
            default:    condMet = 1'b0;
        endcase
    end

    assign branchTaken  = branchId && condMet && !stall; // Wait out flag stall
    assign branchTarget = pcId + 16'd1 + {{7{instrId[8]}}, instrId[8:0]};

    // ID/EX controls, bubble on stall
    always_ff @(posedge clk) begin
        if (reset || stall) begin
            opcode    <= opNop7;
            memRead   <= 1'b0;
            memWrite  <= 1'b0;
            regWrite  <= 1'b0;
            setsFlags <= 1'b0;
        end else begin
            opcode    <= op;
            memRead   <= (op == opLw);
            memWrite  <= storeId;
            regWrite  <= regWriteD && (rd != '0); // r0 writes dropped here
            setsFlags <= setsFlagsD;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        regA <= readDataA;
        regB <= readDataB;
        imm  <= immD;
        rdEx <= rd;
        rsEx <= srcAId;
        rtEx <= srcBId;
    end

endmodule

/* rtl/fetchStage.sv */
module fetchStage #(
    parameter int imemAddrWidth = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     progWrite,
    input  logic [imemAddrWidth-1:0] progAddr,
    input  cpuPkg::wordT             progData,
    input  logic                     stall,        // Hold PC and IF/ID
    input  logic                     branchTaken,
    input  cpuPkg::wordT             branchTarget,
    input  logic                     haltSeen,     // HLT sitting in decode
    output cpuPkg::wordT             pc,
    output cpuPkg::wordT             instrId,
    output cpuPkg::wordT             pcId
);
    import cpuPkg::*;

    wordT imem [2**imemAddrWidth]; // Word addressed program store
    wordT instr;
    logic halted;
    logic freeze;

    assign instr  = imem[pc[imemAddrWidth-1:0]]; // Async read
    assign freeze = halted | haltSeen;

    always_ff @(posedge clk) begin
        if (progWrite) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            halted  <= 1'b0;
            instrId <= nopWord;
        end else if (!stall) begin
            halted <= freeze; // Sticky after HLT decode
            if (!freeze) begin
                pc <= branchTaken ? branchTarget : pc + 16'd1;
            end
            // Flush slot behind a taken branch or HLT
            instrId <= (branchTaken || freeze) ? nopWord : instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcId <= pc; // Branch base
        end
    end

endmodule

/* rtl/registerFile.sv */
module registerFile (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::regAddrT readRegA,
    input  cpuPkg::regAddrT readRegB,
    input  logic            writeEnable,
    input  cpuPkg::regAddrT writeReg,
    input  cpuPkg::wordT    writeData,
    output cpuPkg::wordT    readDataA,
    output cpuPkg::wordT    readDataB
);
    import cpuPkg::*;

    wordT regs [16];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0; // Known state for program start
            end
        end else if (writeEnable && writeReg != '0) begin
            regs[writeReg] <= writeData;
        end
    end

    // Same-cycle write bypass on both read ports
    always_comb begin
        if (readRegA == '0) readDataA = '0;
        else if (writeEnable && writeReg == readRegA) readDataA = writeData;
        else readDataA = regs[readRegA];
    end

    always_comb begin
        if (readRegB == '0) readDataB = '0;
        else if (writeEnable && writeReg == readRegB) readDataB = writeData;
        else readDataB = regs[readRegB];
    end

endmodule

/* rtl/cpuPkg.sv */
package cpuPkg;

    typedef logic [15:0] wordT;    // Data or instruction word
    typedef logic [3:0]  regAddrT; // Register number, r0 reads zero

    // Top nibble of the instruction word
    typedef enum logic [3:0] {
        opAdd  = 4'h0,
        opSub  = 4'h1,
        opXor  = 4'h2,
        opAnd  = 4'h3,
        opSll  = 4'h4,
        opSra  = 4'h5,
        opRor  = 4'h6,
        opNop7 = 4'h7, // No-op, also used as pipeline bubble
        opLw   = 4'h8,
        opSw   = 4'h9,
        opLlb  = 4'hA,
        opLhb  = 4'hB,
        opB    = 4'hC,
        opNopD = 4'hD,
        opNopE = 4'hE,
        opHlt  = 4'hF
    } opcodeT;

    // Branch condition, bits 11..9 of a B instruction
    typedef enum logic [2:0] {
        condNe,
        condEq,
        condGt,
        condLt,
        condGe,
        condLe,
        condOv,
        condAlways
    } condT;

    // Operand source select in execute
    typedef enum logic [1:0] {
        fwdNone,
        fwdFromMem, // EX/MEM result
        fwdFromWb   // MEM/WB writeback value
    } forwardT;

    typedef struct packed {
        logic zero;
        logic overflow;
        logic negative;
    } flagsT;

    localparam wordT nopWord = 16'h7000; // Bubble in IF/ID

endpackage
